// ==== compile.f ====
hdl/pipeCtrlPkg.sv
hdl/stageCtrlIf.sv
hdl/ctrlDecode.sv
hdl/hazardDetect.sv
hdl/forwardUnit.sv
hdl/stageTracker.sv
hdl/pipeCtrlTop.sv
dv/pipeCtrlTb.sv

// ==== dv/pipeCtrlTb.sv ====
// Testbench for the pipeline control block, table-driven with a shadow model of the stage registers
`timescale 1ns/1ns
`default_nettype none

module pipeCtrlTb import pipeCtrlPkg::*; ();

  localparam int ResetCycles = 2;
  localparam int MaxCycles   = 200;  // Watchdog limit

  // One table row per decode-stage instruction and cycle
  typedef struct packed {
    opcode_e    op;
    regId_t     src1;
    regId_t     src2;
    regId_t     dst;
    logic [2:0] miss;   // icacheMiss, dcacheMiss, updatePc
    logic [6:0] bits;   // pc, ifId, idEx, exMem, memFlush, idFlush, ifFlush
    fwdSel_e    fwdA;
    fwdSel_e    fwdB;
    logic       store;  // fwdStoreMem
  } row_t;

  logic    clk;
  logic    rstN;
  opcode_e idOpcode;
  regId_t  srcReg1, srcReg2, dstReg;
  logic    icacheMiss, dcacheMiss, updatePc;
  logic    pcStall, ifIdStall, idExStall, exMemStall;
  logic    memFlush, idFlush, ifFlush;
  fwdSel_e fwdSelA, fwdSelB;
  logic    fwdStoreMem;

  row_t  rows[$];
  string rowNames[$];
  int    dutErrors;
  int    tableErrors;
  int    checkCount;

  // Shadow stage registers
  logic   shExWr, shExLoad, shExStore, shExFlags;
  regId_t shExRd, shExSrc1, shExSrc2;
  regId_t shMemRd, shWbRd;
  logic   shMemWr, shMemStore, shWbWr;

  // Expected outputs of the current row
  logic [6:0] expBits;
  fwdSel_e    expFwdA, expFwdB;
  logic       expStore;

  pipeCtrlTop u_pipeCtrlTop (
    .clk (clk), .rstN (rstN), .idOpcode (idOpcode),
    .srcReg1 (srcReg1), .srcReg2 (srcReg2), .dstReg (dstReg),
    .icacheMiss (icacheMiss), .dcacheMiss (dcacheMiss), .updatePc (updatePc),
    .pcStall (pcStall), .ifIdStall (ifIdStall), .idExStall (idExStall),
    .exMemStall (exMemStall), .memFlush (memFlush), .idFlush (idFlush),
    .ifFlush (ifFlush), .fwdSelA (fwdSelA), .fwdSelB (fwdSelB),
    .fwdStoreMem (fwdStoreMem)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  //////////////////////////////
  // Table helpers
  //////////////////////////////
  task automatic addRow(input string name, input opcode_e op, input regId_t s1,
                        input regId_t s2, input regId_t d, input logic [2:0] miss,
                        input logic [6:0] bits, input fwdSel_e fa, input fwdSel_e fb,
                        input logic st);
    row_t r;
    r = '{op: op, src1: s1, src2: s2, dst: d, miss: miss, bits: bits,
          fwdA: fa, fwdB: fb, store: st};
    rows.push_back(r);
    rowNames.push_back(name);
  endtask

  function automatic string bitName(input int idx);
    case (idx)
      6: return "pcStall";
      5: return "ifIdStall";
      4: return "idExStall";
      3: return "exMemStall";
      2: return "memFlush";
      1: return "idFlush";
      default: return "ifFlush";
    endcase
  endfunction

  //////////////////////////////
  // Shadow model
  //////////////////////////////
  task automatic clearEx();
    shExWr    = 1'b0;  // Bubble in EX
    shExLoad  = 1'b0;
    shExStore = 1'b0;
    shExFlags = 1'b0;
    shExRd    = 4'd0;
    shExSrc1  = 4'd0;
    shExSrc2  = 4'd0;
  endtask

  task automatic resetModel();
    clearEx();
    shMemRd    = 4'd0;
    shMemWr    = 1'b0;
    shMemStore = 1'b0;
    shWbRd     = 4'd0;
    shWbWr     = 1'b0;
  endtask

  // Younger EX/MEM result first and r0 never forwarded
  function automatic fwdSel_e expectedSrc(input regId_t src);
    fwdSel_e sel;
    sel = fwdNone;
    if (shMemWr && (shMemRd != 4'd0) && (shMemRd == src)) begin
      sel = fwdExMem;
    end else if (shWbWr && (shWbRd != 4'd0) && (shWbRd == src)) begin
      sel = fwdMemWb;
    end
    return sel;
  endfunction

  task automatic predictOutputs(input row_t r);
    logic loadUse, bHaz, brHaz, hazard, ifIdExp;
    loadUse = shExLoad && (shExRd != 4'd0) &&
              ((shExRd == r.src1) || ((shExRd == r.src2) && (r.op != opSw)));
    bHaz    = (r.op inside {opB, opBr}) && shExFlags;
    brHaz   = (r.op == opBr) &&
              (shExFlags || (shExWr && (shExRd != 4'd0) && (shExRd == r.src1)) ||
               (shMemWr && (shMemRd != 4'd0) && (shMemRd == r.src1)));
    hazard  = loadUse || bHaz || brHaz;
    ifIdExp = r.miss[1] || hazard;  // Data miss or any hazard
    expBits = {r.miss[2] | ifIdExp, ifIdExp, r.miss[1], r.miss[1], r.miss[1],
               hazard & ~r.miss[1], (r.miss[2] | r.miss[0]) & ~ifIdExp};
    expFwdA  = expectedSrc(shExSrc1);
    expFwdB  = expectedSrc(shExSrc2);
    expStore = shMemStore && shWbWr && (shWbRd != 4'd0) && (shWbRd == shMemRd);
  endtask

  // Clock edge of the shadow registers in WB, MEM, EX order
  task automatic advanceModel(input row_t r);
    if (r.miss[1]) begin
      shWbRd = 4'd0;  // MEM/WB bubble while EX/MEM and ID/EX hold
      shWbWr = 1'b0;
    end else begin
      shWbRd     = shMemRd;
      shWbWr     = shMemWr;
      shMemRd    = shExStore ? shExSrc2 : shExRd;  // Store carries its data register
      shMemWr    = shExWr;
      shMemStore = shExStore;
      if (expBits[1]) begin
        clearEx();
      end else begin
        shExWr    = r.op inside {opAlu, opLogic, opShift, opLw, opLli};
        shExLoad  = (r.op == opLw);
        shExStore = (r.op == opSw);
        shExFlags = r.op inside {opAlu, opLogic, opShift};
        shExRd    = r.dst;
        shExSrc1  = r.src1;
        shExSrc2  = r.src2;
      end
    end
  endtask

  //////////////////////////////
  // Checks
  //////////////////////////////
  task automatic checkBit(input string testName, input string sigName,
                          input logic expVal, input logic actVal);
    checkCount++;
    if (actVal !== expVal) begin
      dutErrors++;
      $display("mismatch %s %s expected %0b actual %0b", testName, sigName, expVal, actVal);
    end
  endtask

  task automatic checkFwd(input string testName, input string sigName,
                          input fwdSel_e expVal, input fwdSel_e actVal);
    checkCount++;
    if (actVal !== expVal) begin
      dutErrors++;
      $display("mismatch %s %s expected %s actual %s (%0d)", testName, sigName,
               expVal.name(), actVal.name(), actVal);
    end
  endtask

  task automatic buildTable();
    // Reset state and load-to-use
    addRow("idle", opNop, 4'd0, 4'd0, 4'd0, 3'b000, 7'b0000000, fwdNone, fwdNone, 1'b0);
    addRow("lw_r3", opLw, 4'd1, 4'd0, 4'd3, 3'b000, 7'b0000000, fwdNone, fwdNone, 1'b0);
    addRow("add_use_r3", opAlu, 4'd3, 4'd4, 4'd5, 3'b000, 7'b1100010, fwdNone, fwdNone, 1'b0);
    addRow("add_retry_r3", opAlu, 4'd3, 4'd4, 4'd5, 3'b000, 7'b0, fwdNone, fwdNone, 1'b0);
    addRow("lw_r3_again", opLw, 4'd2, 4'd0, 4'd3, 3'b000, 7'b0, fwdMemWb, fwdNone, 1'b0);
    addRow("sw_data_r3", opSw, 4'd6, 4'd3, 4'd0, 3'b000, 7'b0, fwdNone, fwdNone, 1'b0);
    addRow("nop_after_sw", opNop, 4'd0, 4'd0, 4'd0, 3'b000, 7'b0, fwdNone, fwdExMem, 1'b0);
    addRow("sw_mem_fwd", opNop, 4'd0, 4'd0, 4'd0, 3'b000, 7'b0, fwdNone, fwdNone, 1'b1);
    // Branches
    addRow("alu_r7", opAlu, 4'd1, 4'd2, 4'd7, 3'b000, 7'b0, fwdNone, fwdNone, 1'b0);
    addRow("b_after_alu", opB, 4'd0, 4'd0, 4'd0, 3'b000, 7'b1100010, fwdNone, fwdNone, 1'b0);
    addRow("b_retry", opB, 4'd0, 4'd0, 4'd0, 3'b000, 7'b0, fwdNone, fwdNone, 1'b0);
    addRow("lli_r8", opLli, 4'd0, 4'd0, 4'd8, 3'b000, 7'b0, fwdNone, fwdNone, 1'b0);
    addRow("br_ex_r8", opBr, 4'd8, 4'd0, 4'd0, 3'b000, 7'b1100010, fwdNone, fwdNone, 1'b0);
    addRow("br_mem_r8", opBr, 4'd8, 4'd0, 4'd0, 3'b000, 7'b1100010, fwdNone, fwdNone, 1'b0);
    addRow("br_clear", opBr, 4'd8, 4'd0, 4'd0, 3'b000, 7'b0, fwdNone, fwdNone, 1'b0);
    addRow("lli_r0", opLli, 4'd0, 4'd0, 4'd0, 3'b000, 7'b0, fwdNone, fwdNone, 1'b0);
    addRow("br_r0_ex", opBr, 4'd0, 4'd0, 4'd0, 3'b000, 7'b0, fwdNone, fwdNone, 1'b0);
    addRow("br_r0_mem", opBr, 4'd0, 4'd0, 4'd0, 3'b000, 7'b0, fwdNone, fwdNone, 1'b0);
    // Forwarding
    addRow("add_r9", opAlu, 4'd1, 4'd2, 4'd9, 3'b000, 7'b0, fwdNone, fwdNone, 1'b0);
    addRow("add_dep_ex", opAlu, 4'd9, 4'd2, 4'd10, 3'b000, 7'b0, fwdNone, fwdNone, 1'b0);
    addRow("or_unrelated", opLogic, 4'd4, 4'd5, 4'd11, 3'b000, 7'b0, fwdExMem, fwdNone, 1'b0);
    addRow("add_dep_wb", opAlu, 4'd10, 4'd4, 4'd12, 3'b000, 7'b0, fwdNone, fwdNone, 1'b0);
    addRow("add_r13_a", opAlu, 4'd1, 4'd1, 4'd13, 3'b000, 7'b0, fwdMemWb, fwdNone, 1'b0);
    addRow("add_r13_b", opAlu, 4'd2, 4'd2, 4'd13, 3'b000, 7'b0, fwdNone, fwdNone, 1'b0);
    addRow("add_use_r13", opAlu, 4'd13, 4'd3, 4'd14, 3'b000, 7'b0, fwdNone, fwdNone, 1'b0);
    addRow("nop_both_match", opNop, 4'd0, 4'd0, 4'd0, 3'b000, 7'b0, fwdExMem, fwdNone, 1'b0);
    // Cache misses and redirects
    addRow("dcache_miss", opNop, 4'd0, 4'd0, 4'd0, 3'b010, 7'b1111100, fwdNone, fwdNone, 1'b0);
    addRow("lw_r4", opLw, 4'd1, 4'd0, 4'd4, 3'b000, 7'b0, fwdNone, fwdNone, 1'b0);
    addRow("dmiss_load_use", opAlu, 4'd4, 4'd5, 4'd6, 3'b010, 7'b1111100, fwdNone, fwdNone, 1'b0);
    addRow("load_use_after", opAlu, 4'd4, 4'd5, 4'd6, 3'b000, 7'b1100010, fwdNone, fwdNone, 1'b0);
    addRow("add_retry_r4", opAlu, 4'd4, 4'd5, 4'd6, 3'b000, 7'b0, fwdNone, fwdNone, 1'b0);
    addRow("icache_miss", opNop, 4'd0, 4'd0, 4'd0, 3'b100, 7'b1000001, fwdMemWb, fwdNone, 1'b0);
    addRow("redirect", opNop, 4'd0, 4'd0, 4'd0, 3'b001, 7'b0000001, fwdNone, fwdNone, 1'b0);
    addRow("redirect_dmiss", opNop, 4'd0, 4'd0, 4'd0, 3'b011, 7'b1111100, fwdNone, fwdNone, 1'b0);
    addRow("alu_r2", opAlu, 4'd1, 4'd1, 4'd2, 3'b000, 7'b0, fwdNone, fwdNone, 1'b0);
    addRow("redirect_b_stall", opB, 4'd0, 4'd0, 4'd0, 3'b001, 7'b1100010, fwdNone, fwdNone, 1'b0);
    addRow("idle_end", opNop, 4'd0, 4'd0, 4'd0, 3'b000, 7'b0, fwdNone, fwdNone, 1'b0);
  endtask

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < MaxCycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("simulation ran past %0d cycles without finishing", MaxCycles);
    $display("ERRORS FOUND");
    $finish;
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin : stimulus
    int         waitCount;
    int         i;
    int         j;
    logic [6:0] actBits;
    rstN        = 1'b0;  // Reset from time zero
    idOpcode    = opNop;
    srcReg1     = 4'd0;
    srcReg2     = 4'd0;
    dstReg      = 4'd0;
    icacheMiss  = 1'b0;
    dcacheMiss  = 1'b0;
    updatePc    = 1'b0;
    dutErrors   = 0;
    tableErrors = 0;
    checkCount  = 0;
    buildTable();
    resetModel();
    waitCount = 0;
    while (waitCount < ResetCycles) begin  // Reset held over two rising edges
      @(posedge clk);
      waitCount++;
    end
    rstN <= 1'b1;
    for (i = 0; i < rows.size(); i++) begin
      @(posedge clk);
      idOpcode   <= rows[i].op;
      srcReg1    <= rows[i].src1;
      srcReg2    <= rows[i].src2;
      dstReg     <= rows[i].dst;
      icacheMiss <= rows[i].miss[2];
      dcacheMiss <= rows[i].miss[1];
      updatePc   <= rows[i].miss[0];
      @(negedge clk);  // Outputs settled mid-cycle
      predictOutputs(rows[i]);
      if ({expBits, expFwdA, expFwdB, expStore} !==
          {rows[i].bits, rows[i].fwdA, rows[i].fwdB, rows[i].store}) begin
        tableErrors++;
        $display("mismatch %s table expected %h actual %h from model", rowNames[i],
                 {rows[i].bits, rows[i].fwdA, rows[i].fwdB, rows[i].store},
                 {expBits, expFwdA, expFwdB, expStore});
      end
      actBits = {pcStall, ifIdStall, idExStall, exMemStall, memFlush, idFlush, ifFlush};
      for (j = 6; j >= 0; j--) begin
        checkBit(rowNames[i], bitName(j), expBits[j], actBits[j]);
      end
      checkFwd(rowNames[i], "fwdSelA", expFwdA, fwdSelA);
      checkFwd(rowNames[i], "fwdSelB", expFwdB, fwdSelB);
      checkBit(rowNames[i], "fwdStoreMem", expStore, fwdStoreMem);
      advanceModel(rows[i]);
    end
    $display("checks %0d dut errors %0d table errors %0d", checkCount, dutErrors, tableErrors);
    if ((dutErrors == 0) && (tableErrors == 0)) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/ctrlDecode.sv ====
// Control decoder turning the decode-stage opcode into pipeline control bits
`timescale 1ns/1ns
`default_nettype none

module ctrlDecode import pipeCtrlPkg::*; (
  input  opcode_e idOpcode,  // Opcode of the instruction in decode
  output ctrl_t   idCtrl     // Decoded control bits
);

  //////////////////////////////
  // Opcode decode
  //////////////////////////////
  always_comb begin
    idCtrl = '0;  // Nop defaults
    case (idOpcode)
      opAlu: begin
        idCtrl.regWrite = 1'b1;
        idCtrl.zEn      = 1'b1;  // Full flag set
        idCtrl.nvEn     = 1'b1;
      end
      opLogic, opShift: begin
        idCtrl.regWrite = 1'b1;
        idCtrl.zEn      = 1'b1;  // Z only
      end
      opLw: begin
        idCtrl.regWrite  = 1'b1;
        idCtrl.memEnable = 1'b1;  // Read access
      end
      opSw: begin
        idCtrl.memEnable = 1'b1;
        idCtrl.memWrite  = 1'b1;  // No rd write
      end
      opLli: begin
        idCtrl.regWrite = 1'b1;  // Immediate into rd
      end
      opB: begin
        idCtrl.branch = 1'b1;
      end
      opBr: begin
        idCtrl.branch = 1'b1;
        idCtrl.br     = 1'b1;  // Target from src1
      end
      opNop, opHlt: begin
        idCtrl = '0;
      end
      default: begin
        idCtrl = '0;  // Unused encodings act as nop
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/forwardUnit.sv ====
// Forwarding unit choosing execute operand sources and the MEM-to-MEM store forward
`timescale 1ns/1ns
`default_nettype none

module forwardUnit import pipeCtrlPkg::*; (
  stageCtrlIf.forward stage,        // Registered stage fields
  output fwdSel_e     fwdSelA,      // Source for EX operand 1
  output fwdSel_e     fwdSelB,      // Source for EX operand 2
  output logic        fwdStoreMem   // Store data from MEM/WB result
);

  // EX/MEM wins over MEM/WB, it is the younger result
  function automatic fwdSel_e pickSrc(
    input regId_t src,
    input regId_t memRd,
    input logic   memRegWrite,
    input regId_t wbRd,
    input logic   wbRegWrite
  );
    fwdSel_e sel;
    sel = fwdNone;
    if (memRegWrite && (memRd != '0) && (memRd == src)) begin
      sel = fwdExMem;
    end else if (wbRegWrite && (wbRd != '0) && (wbRd == src)) begin
      sel = fwdMemWb;
    end
    return sel;
  endfunction

  //////////////////////////////
  // Operand selects
  //////////////////////////////
  assign fwdSelA = pickSrc(stage.exSrc1, stage.memRd, stage.memRegWrite,
                           stage.wbRd, stage.wbRegWrite);
  assign fwdSelB = pickSrc(stage.exSrc2, stage.memRd, stage.memRegWrite,
                           stage.wbRd, stage.wbRegWrite);

  // memRd carries the data register while a store sits in MEM
  assign fwdStoreMem = stage.memMemWrite & stage.wbRegWrite &
                       (stage.wbRd != '0) & (stage.wbRd == stage.memRd);

endmodule

`default_nettype wire

// ==== hdl/hazardDetect.sv ====
// Hazard detector for load-to-use and branch hazards, with stall and flush generation
`timescale 1ns/1ns
`default_nettype none

module hazardDetect import pipeCtrlPkg::*; (
  input  ctrl_t             idCtrl,      // Decode-stage control bits
  input  regId_t            srcReg1,     // Decode rs
  input  regId_t            srcReg2,     // Decode rt
  input  logic              icacheMiss,  // Fetch not ready
  input  logic              dcacheMiss,  // Memory stage not ready
  input  logic              updatePc,    // Redirect from a taken branch
  stageCtrlIf.hazard        stage,       // Registered stage fields
  output logic              pcStall,
  output logic              ifIdStall,
  output logic              idExStall,
  output logic              exMemStall,
  output logic              memFlush,    // Bubble into MEM/WB
  output logic              idFlush,     // Bubble into ID/EX
  output logic              ifFlush      // Kill the fetched word
);

  logic exIsLoad;     // EX holds a load
  logic exSetsFlags;  // EX writes any flag
  logic exRdValid;    // EX writes a real register
  logic memRdValid;   // MEM writes a real register
  logic loadUseHaz;
  logic bHaz;
  logic brHaz;
  logic anyHaz;

  //////////////////////////////
  // Stage qualifiers
  //////////////////////////////
  assign exIsLoad    = stage.exCtrl.memEnable & ~stage.exCtrl.memWrite;
  assign exSetsFlags = stage.exCtrl.zEn | stage.exCtrl.nvEn;
  assign exRdValid   = stage.exCtrl.regWrite & (stage.exRd != '0);
  assign memRdValid  = stage.memRegWrite & (stage.memRd != '0);

  //////////////////////////////
  // Hazard terms
  //////////////////////////////
  // Store data on src2 is covered by the MEM-to-MEM forward
  assign loadUseHaz = exIsLoad & (stage.exRd != '0) &
                      ((stage.exRd == srcReg1) |
                       ((stage.exRd == srcReg2) & ~idCtrl.memWrite));

  assign bHaz = idCtrl.branch & exSetsFlags;  // Flags not yet settled

  // BR needs flags and its target register resolved in decode
  assign brHaz = idCtrl.branch & idCtrl.br &
                 (exSetsFlags |
                  (exRdValid & (stage.exRd == srcReg1)) |
                  (memRdValid & (stage.memRd == srcReg1)));

  assign anyHaz = loadUseHaz | bHaz | brHaz;

  //////////////////////////////
  // Stalls
  //////////////////////////////
  assign exMemStall = dcacheMiss;                 // Whole back end waits on the data cache
  assign idExStall  = exMemStall;
  assign ifIdStall  = exMemStall | anyHaz;        // Decode waits behind any hazard
  assign pcStall    = icacheMiss | ifIdStall;

  //////////////////////////////
  // Flushes
  //////////////////////////////
  assign memFlush = dcacheMiss;                   // Bubble behind the stalled MEM
  assign idFlush  = anyHaz & ~idExStall;          // Nop into EX only while EX moves
  assign ifFlush  = (icacheMiss | updatePc) & ~ifIdStall;

endmodule

`default_nettype wire

// ==== hdl/pipeCtrlPkg.sv ====
// Pipeline control package with register IDs, opcodes, forward selects and decoded control bits
`default_nettype none

package pipeCtrlPkg;

  //////////////////////////////
  // Basic field types
  //////////////////////////////
  typedef logic [3:0] regId_t;  // Sixteen registers, r0 never a hazard source

  // Instruction classes seen by the decode stage
  typedef enum logic [3:0] {
    opAlu   = 4'h0,  // Arithmetic, sets Z, N and V
    opLogic = 4'h1,  // Sets Z only
    opShift = 4'h2,  // Sets Z only
    opLw    = 4'h3,  // Load word
    opSw    = 4'h4,  // Store word
    opLli   = 4'h5,  // Load immediate into rd
    opB     = 4'h6,  // Conditional branch on flags
    opBr    = 4'h7,  // Branch to register
    opNop   = 4'h8,
    opHlt   = 4'h9
  } opcode_e;

  // Source of an execute-stage operand
  typedef enum logic [1:0] {
    fwdNone  = 2'd0,  // Register file value
    fwdExMem = 2'd1,  // EX/MEM result
    fwdMemWb = 2'd2   // MEM/WB result
  } fwdSel_e;

  //////////////////////////////
  // Decoded control bits
  //////////////////////////////
  typedef struct packed {
    logic regWrite;   // Writes rd at WB
    logic memEnable;  // Data memory access
    logic memWrite;   // Store when set with memEnable
    logic zEn;        // Updates Z flag
    logic nvEn;       // Updates N and V flags
    logic branch;     // Any branch
    logic br;         // Register-target branch
  } ctrl_t;

endpackage

`default_nettype wire

// ==== hdl/pipeCtrlTop.sv ====
// Pipeline control top level joining decode, hazard, forwarding and stage tracking
`timescale 1ns/1ns
`default_nettype none

module pipeCtrlTop import pipeCtrlPkg::*; (
  input  logic    clk,
  input  logic    rstN,         // Async, active low
  input  opcode_e idOpcode,     // Decode-stage opcode
  input  regId_t  srcReg1,      // Decode rs
  input  regId_t  srcReg2,      // Decode rt
  input  regId_t  dstReg,       // Decode rd
  input  logic    icacheMiss,
  input  logic    dcacheMiss,
  input  logic    updatePc,     // PC redirect
  output logic    pcStall,
  output logic    ifIdStall,
  output logic    idExStall,
  output logic    exMemStall,
  output logic    memFlush,
  output logic    idFlush,
  output logic    ifFlush,
  output fwdSel_e fwdSelA,      // EX operand 1 source
  output fwdSel_e fwdSelB,      // EX operand 2 source
  output logic    fwdStoreMem   // Store data forward
);

  ctrl_t idCtrl;  // Decoded bits shared by hazard and tracker

  stageCtrlIf stage ();  // Registered stage fields

  ctrlDecode u_ctrlDecode (
    .idOpcode (idOpcode),
    .idCtrl   (idCtrl)
  );

  //////////////////////////////
  // Hazards, stalls and flushes
  //////////////////////////////
  hazardDetect u_hazardDetect (
    .idCtrl     (idCtrl),
    .srcReg1    (srcReg1),
    .srcReg2    (srcReg2),
    .icacheMiss (icacheMiss),
    .dcacheMiss (dcacheMiss),
    .updatePc   (updatePc),
    .stage      (stage.hazard),
    .pcStall    (pcStall),
    .ifIdStall  (ifIdStall),
    .idExStall  (idExStall),
    .exMemStall (exMemStall),
    .memFlush   (memFlush),
    .idFlush    (idFlush),
    .ifFlush    (ifFlush)
  );

  forwardUnit u_forwardUnit (
    .stage       (stage.forward),
    .fwdSelA     (fwdSelA),
    .fwdSelB     (fwdSelB),
    .fwdStoreMem (fwdStoreMem)
  );

  //////////////////////////////
  // Stage registers
  //////////////////////////////
  stageTracker u_stageTracker (
    .clk        (clk),
    .rstN       (rstN),
    .idCtrl     (idCtrl),
    .srcReg1    (srcReg1),
    .srcReg2    (srcReg2),
    .dstReg     (dstReg),
    .idExStall  (idExStall),   // Same level as exMemStall today
    .exMemStall (exMemStall),
    .idFlush    (idFlush),
    .memFlush   (memFlush),
    .stage      (stage.tracker)
  );

endmodule

`default_nettype wire

// ==== hdl/stageCtrlIf.sv ====
// Stage control interface carrying registered ID/EX, EX/MEM and MEM/WB fields
`timescale 1ns/1ns
`default_nettype none

interface stageCtrlIf import pipeCtrlPkg::*; ();

  // ID/EX fields
  ctrl_t  exCtrl;       // Control bits of the EX instruction
  regId_t exRd;         // Destination of the EX instruction
  regId_t exSrc1;
  regId_t exSrc2;       // Also the store data register

  // EX/MEM fields
  regId_t memRd;        // rd, or the data register of a store
  logic   memRegWrite;
  logic   memMemWrite;

  // MEM/WB fields
  regId_t wbRd;
  logic   wbRegWrite;

  modport tracker (
    output exCtrl, exRd, exSrc1, exSrc2,
    output memRd, memRegWrite, memMemWrite,
    output wbRd, wbRegWrite
  );

  modport hazard (input exCtrl, exRd, memRd, memRegWrite);

  modport forward (input exSrc1, exSrc2, memRd, memRegWrite, memMemWrite, wbRd, wbRegWrite);

endinterface

`default_nettype wire

// ==== hdl/stageTracker.sv ====
// Stage tracker holding the ID/EX, EX/MEM and MEM/WB control fields
`timescale 1ns/1ns
`default_nettype none

module stageTracker import pipeCtrlPkg::*; (
  input  logic        clk,
  input  logic        rstN,        // Async, active low
  input  ctrl_t       idCtrl,      // Decoded bits of the decode instruction
  input  regId_t      srcReg1,
  input  regId_t      srcReg2,
  input  regId_t      dstReg,
  input  logic        idExStall,   // Hold ID/EX
  input  logic        exMemStall,  // Hold EX/MEM
  input  logic        idFlush,     // Bubble into ID/EX
  input  logic        memFlush,    // Bubble into MEM/WB
  stageCtrlIf.tracker stage
);

  //////////////////////////////
  // ID/EX register
  //////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      stage.exCtrl <= '0;  // Bubble
      stage.exRd   <= '0;
      stage.exSrc1 <= '0;
      stage.exSrc2 <= '0;
    end else if (idExStall) begin
      // Hold the EX instruction
    end else if (idFlush) begin
      stage.exCtrl <= '0;  // Nop into EX
      stage.exRd   <= '0;
      stage.exSrc1 <= '0;
      stage.exSrc2 <= '0;
    end else begin
      stage.exCtrl <= idCtrl;
      stage.exRd   <= dstReg;
      stage.exSrc1 <= srcReg1;
      stage.exSrc2 <= srcReg2;
    end
  end

  //////////////////////////////
  // EX/MEM register
  //////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      stage.memRd       <= '0;
      stage.memRegWrite <= 1'b0;
      stage.memMemWrite <= 1'b0;
    end else if (!exMemStall) begin
      // A store carries its data register for the MEM-to-MEM forward
      stage.memRd       <= stage.exCtrl.memWrite ? stage.exSrc2 : stage.exRd;
      stage.memRegWrite <= stage.exCtrl.regWrite;
      stage.memMemWrite <= stage.exCtrl.memWrite;
    end
  end

  //////////////////////////////
  // MEM/WB register
  //////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      stage.wbRd       <= '0;
      stage.wbRegWrite <= 1'b0;
    end else if (memFlush) begin
      stage.wbRd       <= '0;  // Bubble while MEM waits on the cache
      stage.wbRegWrite <= 1'b0;
    end else begin
      stage.wbRd       <= stage.memRd;
      stage.wbRegWrite <= stage.memRegWrite;
    end
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the pipeline control testbench with Verilator
cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --timescale 1ns/1ns -f compile.f \
  --top-module pipeCtrlTb -Mdir "$buildDir" -o pipeCtrlSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$buildDir/pipeCtrlSim" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -q "ERRORS FOUND" "$logFile"; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"
exit 0
